// File: rtl/ant_draw.sv
`timescale 1ns/10ps

module ant_draw #(
    parameter int ant_width = 4,
    parameter int ant_height = 4
) (
    input logic clock,
    input logic resetn,
    input logic start,
    output logic finished,
    input logic [ant_pkg::id_width-1:0] id,
    dp_cmd_if.requester cmd
);
    import ant_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_read_x = 2'd1;
    localparam logic [1:0] st_read_y = 2'd2;
    localparam logic [1:0] st_plot = 2'd3;

    localparam logic [x_coord_width-1:0] dx_last = x_coord_width'(ant_width - 1);
    localparam logic [y_coord_width-1:0] dy_last = y_coord_width'(ant_height - 1);

    logic [1:0] state;
    logic [id_width-1:0] ant_id;
    logic [x_coord_width-1:0] corner_x;
    logic [y_coord_width-1:0] corner_y;
    logic [y_coord_width-1:0] loaded_y;
    logic [x_coord_width-1:0] dx;
    logic [y_coord_width-1:0] dy;
    logic [x_coord_width-1:0] next_dx;
    logic [y_coord_width-1:0] next_dy;
    logic x_wrap;
    logic last_pixel;
    instr_u read_word;
    instr_u plot_word;

    // X offset runs fastest, Y steps when X wraps
    assign x_wrap = (dx == dx_last);
    assign last_pixel = x_wrap && (dy == dy_last);
    assign next_dx = x_wrap ? '0 : dx + 1'b1;
    assign next_dy = x_wrap ? dy + 1'b1 : dy;

    // Sprite corner sits one pixel up and left of the ant position
    assign loaded_y = cmd.result[y_coord_width-1:0] - 1'b1;

    assign read_word = mem_instr(opcode_memread,
                                 (state == st_idle) ? ant_field_addr(id, field_x)
                                                    : ant_field_addr(ant_id, field_y),
                                 '0);

    always_comb begin
        plot_word = '0;
        plot_word.draw.opcode = opcode_draw;
        plot_word.draw.plot = 1'b1;
        plot_word.draw.colour = colour_ant;
        if (state == st_read_y) begin
            // First pixel, corner Y arrives with this done
            plot_word.draw.x = corner_x;
            plot_word.draw.y = loaded_y;
        end else begin
            plot_word.draw.x = corner_x + next_dx;
            plot_word.draw.y = corner_y + next_dy;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_idle;
            finished <= 1'b1;
            cmd.issue <= 1'b0;
            dx <= '0;
            dy <= '0;
        end else begin
            cmd.issue <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_read_x;
                        finished <= 1'b0;
                        cmd.issue <= 1'b1;
                    end
                end
                st_read_x: begin
                    if (cmd.done) begin
                        state <= st_read_y;
                        cmd.issue <= 1'b1;
                    end
                end
                st_read_y: begin
                    if (cmd.done) begin
                        state <= st_plot;
                        cmd.issue <= 1'b1;
                    end
                end
                default: begin
                    if (cmd.done && last_pixel) begin
                        state <= st_idle;
                        finished <= 1'b1;
                        dx <= '0;
                        dy <= '0;
                    end else if (cmd.done) begin
                        cmd.issue <= 1'b1;
                        dx <= next_dx;
                        dy <= next_dy;
                    end
                end
            endcase
        end
    end

    // Next instruction is loaded together with its issue pulse
    always_ff @(posedge clock) begin
        if (state == st_idle && start) begin
            ant_id <= id;
            cmd.instruction <= read_word;
        end else if (state == st_read_x && cmd.done) begin
            corner_x <= cmd.result[x_coord_width-1:0] - 1'b1;
            cmd.instruction <= read_word;
        end else if (state == st_read_y && cmd.done) begin
            corner_y <= loaded_y;
            cmd.instruction <= plot_word;
        end else if (state == st_plot && cmd.done) begin
            cmd.instruction <= plot_word;
        end
    end

    offsets_in_sprite: assert property (
        @(posedge clock) disable iff (!resetn)
        state == st_plot |-> (dx <= dx_last) && (dy <= dy_last)
    );

endmodule

// File: rtl/ant_pkg.sv
package ant_pkg;

    // Screen geometry and pixel format
    localparam int x_coord_width = 8;
    localparam int y_coord_width = 7;
    localparam int colour_width = 3;

    // Red in the 3-bit RGB frame buffer
    localparam logic [colour_width-1:0] colour_ant = 3'b100;

    // Ant memory, one word per record field
    localparam int id_width = 8;
    localparam int field_width = 2;
    localparam int mem_addr_width = 10;

    localparam logic [field_width-1:0] field_x = 2'd0;
    localparam logic [field_width-1:0] field_y = 2'd1;
    localparam logic [field_width-1:0] field_fitness = 2'd2;

    localparam int result_width = 16;

    // Datapath opcodes
    localparam int opcode_width = 3;
    localparam logic [opcode_width-1:0] opcode_memread = 3'd1;
    localparam logic [opcode_width-1:0] opcode_memwrite = 3'd2;
    localparam logic [opcode_width-1:0] opcode_draw = 3'd3;

    localparam int instruction_width = 32;

    typedef logic [result_width-1:0] result_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } move_t;

    // The datapath picks the view from the opcode in the low bits
    typedef union packed {
        struct packed {
            logic [instruction_width-opcode_width-mem_addr_width-result_width-1:0] pad;
            result_t data;
            logic [mem_addr_width-1:0] addr;
            logic [opcode_width-1:0] opcode;
        } mem;
        struct packed {
            logic [instruction_width-opcode_width-x_coord_width-y_coord_width
                   -colour_width-2:0] pad;
            logic plot;
            logic [colour_width-1:0] colour;
            logic [y_coord_width-1:0] y;
            logic [x_coord_width-1:0] x;
            logic [opcode_width-1:0] opcode;
        } draw;
    } instr_u;

    // Record address is the ant id with the field code below it
    function automatic logic [mem_addr_width-1:0] ant_field_addr(
        input logic [id_width-1:0] id,
        input logic [field_width-1:0] field
    );
        return {id, field};
    endfunction

    function automatic instr_u mem_instr(
        input logic [opcode_width-1:0] opcode,
        input logic [mem_addr_width-1:0] addr,
        input result_t data
    );
        instr_u word;
        word = '0;
        word.mem.opcode = opcode;
        word.mem.addr = addr;
        word.mem.data = data;
        return word;
    endfunction

endpackage

// File: rtl/ant_top.sv
`timescale 1ns/10ps

module ant_top #(
    parameter int ant_width = 4,
    parameter int ant_height = 4,
    parameter int screen_width = 160,
    parameter int screen_height = 120
) (
    input logic clock,
    input logic resetn,
    input logic draw_start,
    output logic draw_finished,
    input logic update_start,
    output logic update_finished,
    input logic [ant_pkg::id_width-1:0] id,
    input logic [3:0] move,
    output logic start_dp,
    output logic [ant_pkg::instruction_width-1:0] instruction_dp,
    input logic finished_dp,
    input logic [ant_pkg::result_width-1:0] result_dp
);

    dp_cmd_if draw_cmd ();
    dp_cmd_if update_cmd ();
    dp_cmd_if seq_cmd ();

    ant_draw #(
        .ant_width (ant_width),
        .ant_height(ant_height)
    ) u_ant_draw (
        .clock   (clock),
        .resetn  (resetn),
        .start   (draw_start),
        .finished(draw_finished),
        .id      (id),
        .cmd     (draw_cmd)
    );

    ant_update #(
        .ant_width    (ant_width),
        .ant_height   (ant_height),
        .screen_width (screen_width),
        .screen_height(screen_height)
    ) u_ant_update (
        .clock   (clock),
        .resetn  (resetn),
        .start   (update_start),
        .finished(update_finished),
        .id      (id),
        .move    (move),
        .cmd     (update_cmd)
    );

    // Both engines share the single datapath port
    dp_arbiter u_dp_arbiter (
        .clock     (clock),
        .resetn    (resetn),
        .draw_cmd  (draw_cmd),
        .update_cmd(update_cmd),
        .seq_cmd   (seq_cmd)
    );

    dp_sequencer u_dp_sequencer (
        .clock         (clock),
        .resetn        (resetn),
        .cmd           (seq_cmd),
        .start_dp      (start_dp),
        .instruction_dp(instruction_dp),
        .finished_dp   (finished_dp),
        .result_dp     (result_dp)
    );

endmodule

// File: rtl/ant_update.sv
`timescale 1ns/10ps

module ant_update #(
    parameter int ant_width = 4,
    parameter int ant_height = 4,
    parameter int screen_width = 160,
    parameter int screen_height = 120
) (
    input logic clock,
    input logic resetn,
    input logic start,
    output logic finished,
    input logic [ant_pkg::id_width-1:0] id,
    input ant_pkg::move_t move,
    dp_cmd_if.requester cmd
);
    import ant_pkg::*;

    // One state per command, in issue order
    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_read_x = 3'd1;
    localparam logic [2:0] st_read_y = 3'd2;
    localparam logic [2:0] st_read_fit = 3'd3;
    localparam logic [2:0] st_write_x = 3'd4;
    localparam logic [2:0] st_write_y = 3'd5;
    localparam logic [2:0] st_write_fit = 3'd6;

    // Keep the whole sprite on screen
    localparam logic [x_coord_width-1:0] x_min = x_coord_width'(ant_width / 2);
    localparam logic [x_coord_width-1:0] x_max =
        x_coord_width'(screen_width - ant_width / 2 - 1);
    localparam logic [y_coord_width-1:0] y_min = y_coord_width'(ant_height / 2);
    localparam logic [y_coord_width-1:0] y_max =
        y_coord_width'(screen_height - ant_height / 2 - 1);

    logic [2:0] state;
    logic [id_width-1:0] ant_id;
    move_t move_q;
    logic [x_coord_width-1:0] pos_x;
    logic [y_coord_width-1:0] pos_y;
    result_t fitness;
    logic [x_coord_width-1:0] moved_x;
    logic [y_coord_width-1:0] moved_y;
    instr_u next_word;

    // Each direction is checked against the position as loaded
    always_comb begin
        moved_x = pos_x;
        moved_y = pos_y;
        if (move_q.left && pos_x > x_min) begin
            moved_x = moved_x - 1'b1;
        end
        if (move_q.right && pos_x < x_max) begin
            moved_x = moved_x + 1'b1;
        end
        if (move_q.up && pos_y > y_min) begin
            moved_y = moved_y - 1'b1;
        end
        if (move_q.down && pos_y < y_max) begin
            moved_y = moved_y + 1'b1;
        end
    end

    // Instruction for the command that follows the current state
    always_comb begin
        case (state)
            st_idle:
                next_word = mem_instr(opcode_memread, ant_field_addr(id, field_x), '0);
            st_read_x:
                next_word = mem_instr(opcode_memread, ant_field_addr(ant_id, field_y), '0);
            st_read_y:
                next_word = mem_instr(opcode_memread,
                                      ant_field_addr(ant_id, field_fitness), '0);
            st_read_fit:
                next_word = mem_instr(opcode_memwrite, ant_field_addr(ant_id, field_x),
                                      result_t'(moved_x));
            st_write_x:
                next_word = mem_instr(opcode_memwrite, ant_field_addr(ant_id, field_y),
                                      result_t'(pos_y));
            default:
                next_word = mem_instr(opcode_memwrite,
                                      ant_field_addr(ant_id, field_fitness), fitness);
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_idle;
            finished <= 1'b1;
            cmd.issue <= 1'b0;
        end else begin
            cmd.issue <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_read_x;
                        finished <= 1'b0;
                        cmd.issue <= 1'b1;
                    end
                end
                st_write_fit: begin
                    if (cmd.done) begin
                        state <= st_idle;
                        finished <= 1'b1;
                    end
                end
                default: begin
                    if (cmd.done) begin
                        state <= state + 3'd1;
                        cmd.issue <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_idle && start) begin
            ant_id <= id;
            move_q <= move;
            cmd.instruction <= next_word;
        end else if (state != st_idle && cmd.done) begin
            cmd.instruction <= next_word;
            case (state)
                st_read_x: pos_x <= cmd.result[x_coord_width-1:0];
                st_read_y: pos_y <= cmd.result[y_coord_width-1:0];
                st_read_fit: begin
                    // Fitness passes through untouched
                    fitness <= cmd.result;
                    pos_y <= moved_y;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: rtl/dp_arbiter.sv
`timescale 1ns/10ps

module dp_arbiter (
    input logic clock,
    input logic resetn,
    dp_cmd_if.server draw_cmd,
    dp_cmd_if.server update_cmd,
    dp_cmd_if.requester seq_cmd
);

    logic busy;
    logic owner_update;
    logic draw_pending;
    logic update_pending;
    logic update_req;
    logic draw_req;
    logic grant_update;
    logic grant_draw;

    // A request is either fresh this cycle or held from an earlier loss
    assign update_req = update_cmd.issue | update_pending;
    assign draw_req = draw_cmd.issue | draw_pending;

    // Update has priority over draw
    assign grant_update = ~busy & update_req;
    assign grant_draw = ~busy & ~update_req & draw_req;

    // Requesters keep their instruction steady until done, so a pending
    // request can still be forwarded from the live bus
    assign seq_cmd.issue = grant_update | grant_draw;
    assign seq_cmd.instruction = grant_update ? update_cmd.instruction
                                              : draw_cmd.instruction;

    // Completion goes back to the owner only
    assign update_cmd.done = seq_cmd.done & owner_update;
    assign draw_cmd.done = seq_cmd.done & ~owner_update;
    assign update_cmd.result = seq_cmd.result;
    assign draw_cmd.result = seq_cmd.result;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy <= 1'b0;
            owner_update <= 1'b0;
            draw_pending <= 1'b0;
            update_pending <= 1'b0;
        end else begin
            if (seq_cmd.issue) begin
                busy <= 1'b1;
                owner_update <= grant_update;
            end else if (seq_cmd.done) begin
                busy <= 1'b0;
            end
            update_pending <= update_req & ~grant_update;
            draw_pending <= draw_req & ~grant_draw;
        end
    end

    // Completion only comes back for a command that was forwarded
    done_only_in_flight: assert property (
        @(posedge clock) disable iff (!resetn)
        seq_cmd.done |-> busy
    );

endmodule

// File: rtl/dp_cmd_if.sv
`timescale 1ns/10ps

interface dp_cmd_if;
    import ant_pkg::*;

    // One-cycle request with its instruction
    logic issue;
    instr_u instruction;

    // One-cycle completion, result valid with it
    logic done;
    result_t result;

    modport requester (
        output issue,
        output instruction,
        input done,
        input result
    );

    modport server (
        input issue,
        input instruction,
        output done,
        output result
    );

endinterface

// File: rtl/dp_sequencer.sv
`timescale 1ns/10ps

module dp_sequencer (
    input logic clock,
    input logic resetn,
    dp_cmd_if.server cmd,
    output logic start_dp,
    output ant_pkg::instr_u instruction_dp,
    input logic finished_dp,
    input ant_pkg::result_t result_dp
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_start_a = 2'd1;
    localparam logic [1:0] st_start_b = 2'd2;
    localparam logic [1:0] st_wait = 2'd3;

    logic [1:0] state;

    // Start level is held for two cycles, then we wait for finished
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_idle;
            start_dp <= 1'b0;
            instruction_dp <= '0;
            cmd.done <= 1'b0;
        end else begin
            cmd.done <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd.issue) begin
                        state <= st_start_a;
                        start_dp <= 1'b1;
                        instruction_dp <= cmd.instruction;
                    end
                end
                st_start_a: begin
                    state <= st_start_b;
                end
                st_start_b: begin
                    state <= st_wait;
                    start_dp <= 1'b0;
                end
                default: begin
                    if (finished_dp) begin
                        state <= st_idle;
                        cmd.done <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Result is captured in the cycle finished is first seen
    always_ff @(posedge clock) begin
        if (state == st_wait && finished_dp) begin
            cmd.result <= result_dp;
        end
    end

    // The arbiter must never hand over a command while one is in flight
    issue_only_when_idle: assert property (
        @(posedge clock) disable iff (!resetn)
        cmd.issue |-> state == st_idle
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f src.f --top-module tb_ant_top

status=0
output=$(./obj_dir/Vtb_ant_top 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
echo "Simulator exit status: $status"
exit 1

// File: src.f
rtl/ant_pkg.sv
rtl/dp_cmd_if.sv
rtl/dp_sequencer.sv
rtl/dp_arbiter.sv
rtl/ant_draw.sv
rtl/ant_update.sv
rtl/ant_top.sv
test/tb_datapath_model.sv
test/tb_ant_top.sv

// File: test/tb_ant_top.sv
`timescale 1ns/10ps

module tb_ant_top;
    import ant_pkg::*;

    localparam int clock_period = 8;
    localparam int ant_width = 4;
    localparam int ant_height = 4;
    localparam int screen_width = 160;
    localparam int screen_height = 120;

    localparam int op_draw = 0;
    localparam int op_update = 1;
    localparam int op_both = 2;

    // Limits on the ant position so the sprite stays on screen
    localparam result_t x_low = result_t'(ant_width / 2);
    localparam result_t x_high = result_t'(screen_width - ant_width / 2 - 1);
    localparam result_t y_low = result_t'(ant_height / 2);
    localparam result_t y_high = result_t'(screen_height - ant_height / 2 - 1);

    typedef struct {
        int op;
        logic [id_width-1:0] id;
        result_t x;
        result_t y;
        result_t fitness;
        move_t move;
    } row_t;

    logic clock = 1'b0;
    logic resetn;
    logic draw_start;
    logic draw_finished;
    logic update_start;
    logic update_finished;
    logic [id_width-1:0] id;
    logic [3:0] move;
    logic start_dp;
    logic [instruction_width-1:0] instruction_dp;
    logic finished_dp;
    result_t result_dp;
    logic preload_en;
    logic [id_width-1:0] preload_id;
    result_t preload_x;
    result_t preload_y;
    result_t preload_fitness;

    row_t rows[$];
    int start_cycles;
    logic finished_seen;

    always #(clock_period / 2) clock = ~clock;

    ant_top #(
        .ant_width    (ant_width),
        .ant_height   (ant_height),
        .screen_width (screen_width),
        .screen_height(screen_height)
    ) u_ant_top (
        .clock          (clock),
        .resetn         (resetn),
        .draw_start     (draw_start),
        .draw_finished  (draw_finished),
        .update_start   (update_start),
        .update_finished(update_finished),
        .id             (id),
        .move           (move),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

    tb_datapath_model u_datapath_model (
        .clock          (clock),
        .resetn         (resetn),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp),
        .preload_en     (preload_en),
        .preload_id     (preload_id),
        .preload_x      (preload_x),
        .preload_y      (preload_y),
        .preload_fitness(preload_fitness)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_instr(input string name, input instr_u got, input instr_u exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("[FAIL] %0t %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_coord(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("[FAIL] %0t %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_finished(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("[FAIL] %0t %s got %b expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic add_row(input int op, input logic [id_width-1:0] ant, input result_t x,
                           input result_t y, input result_t fitness, input move_t m);
        row_t r;
        r.op = op;
        r.id = ant;
        r.x = x;
        r.y = y;
        r.fitness = fitness;
        r.move = m;
        rows.push_back(r);
    endtask

    // Move bits are left, right, up, down from MSB
    task automatic load_table();
        add_row(op_draw, 8'd5, 16'd40, 16'd30, 16'd0, 4'b0000);
        add_row(op_update, 8'd7, 16'd80, 16'd60, 16'd321, 4'b1000);
        add_row(op_update, 8'd7, 16'd80, 16'd60, 16'd322, 4'b0100);
        add_row(op_update, 8'd7, 16'd80, 16'd60, 16'd323, 4'b0010);
        add_row(op_update, 8'd7, 16'd80, 16'd60, 16'd324, 4'b0001);
        add_row(op_update, 8'd12, 16'd2, 16'd60, 16'd1000, 4'b1000);
        add_row(op_update, 8'd12, 16'd157, 16'd60, 16'd1001, 4'b0100);
        add_row(op_update, 8'd12, 16'd80, 16'd2, 16'd1002, 4'b0010);
        add_row(op_update, 8'd12, 16'd80, 16'd117, 16'd1003, 4'b0001);
        add_row(op_update, 8'd20, 16'd2, 16'd2, 16'hbeef, 4'b1010);
        add_row(op_update, 8'd20, 16'd157, 16'd117, 16'hcafe, 4'b0101);
        add_row(op_update, 8'd20, 16'd2, 16'd60, 16'h0042, 4'b1001);
        add_row(op_update, 8'd20, 16'd80, 16'd60, 16'h0043, 4'b1100);
        add_row(op_draw, 8'd255, 16'd157, 16'd117, 16'd0, 4'b0000);
        add_row(op_both, 8'd9, 16'd80, 16'd60, 16'd777, 4'b0101);
    endtask

    function automatic result_t expected_x(input result_t x, input move_t m);
        result_t nx;
        nx = x;
        if (m.left && x > x_low) nx = nx - 16'd1;
        if (m.right && x < x_high) nx = nx + 16'd1;
        return nx;
    endfunction

    function automatic result_t expected_y(input result_t y, input move_t m);
        result_t ny;
        ny = y;
        if (m.up && y > y_low) ny = ny - 16'd1;
        if (m.down && y < y_high) ny = ny + 16'd1;
        return ny;
    endfunction

    task automatic expect_log_length(input int base, input int count);
        int seen;
        seen = u_datapath_model.log_size() - base;
        if (seen != count) begin
            stop_with_failure($sformatf("Expected %0d datapath commands but the model saw %0d",
                                        count, seen));
        end
    endtask

    task automatic expect_mem_cmd(input int idx, input logic [opcode_width-1:0] opcode,
                                  input logic [mem_addr_width-1:0] addr, input result_t data);
        instr_u exp;
        exp = '0;
        exp.mem.opcode = opcode;
        exp.mem.addr = addr;
        exp.mem.data = data;
        check_instr($sformatf("instruction_dp[%0d]", idx), u_datapath_model.log_entry(idx), exp);
    endtask

    task automatic expect_draw_stream(input int base, input logic [id_width-1:0] ant,
                                      input result_t x, input result_t y);
        logic [x_coord_width-1:0] cx;
        logic [y_coord_width-1:0] cy;
        instr_u exp;
        int idx;
        expect_mem_cmd(base, opcode_memread, ant_field_addr(ant, field_x), '0);
        expect_mem_cmd(base + 1, opcode_memread, ant_field_addr(ant, field_y), '0);
        cx = x[x_coord_width-1:0] - x_coord_width'(1);
        cy = y[y_coord_width-1:0] - y_coord_width'(1);
        idx = base + 2;
        for (int dy = 0; dy < ant_height; dy++) begin
            for (int dx = 0; dx < ant_width; dx++) begin
                exp = '0;
                exp.draw.opcode = opcode_draw;
                exp.draw.plot = 1'b1;
                exp.draw.colour = colour_ant;
                exp.draw.x = cx + x_coord_width'(dx);
                exp.draw.y = cy + y_coord_width'(dy);
                check_instr($sformatf("instruction_dp[%0d]", idx),
                            u_datapath_model.log_entry(idx), exp);
                idx++;
            end
        end
    endtask

    task automatic expect_update_stream(input int base, input row_t r,
                                        input result_t ux, input result_t uy);
        expect_mem_cmd(base, opcode_memread, ant_field_addr(r.id, field_x), '0);
        expect_mem_cmd(base + 1, opcode_memread, ant_field_addr(r.id, field_y), '0);
        expect_mem_cmd(base + 2, opcode_memread, ant_field_addr(r.id, field_fitness), '0);
        expect_mem_cmd(base + 3, opcode_memwrite, ant_field_addr(r.id, field_x), ux);
        expect_mem_cmd(base + 4, opcode_memwrite, ant_field_addr(r.id, field_y), uy);
        expect_mem_cmd(base + 5, opcode_memwrite, ant_field_addr(r.id, field_fitness),
                       r.fitness);
        check_coord("stored x", u_datapath_model.mem_word(ant_field_addr(r.id, field_x)), ux);
        check_coord("stored y", u_datapath_model.mem_word(ant_field_addr(r.id, field_y)), uy);
        check_coord("stored fitness",
                    u_datapath_model.mem_word(ant_field_addr(r.id, field_fitness)), r.fitness);
    endtask

    task automatic run_row(input row_t r);
        int base;
        result_t ux;
        result_t uy;
        @(negedge clock);
        preload_en = 1'b1;
        preload_id = r.id;
        preload_x = r.x;
        preload_y = r.y;
        preload_fitness = r.fitness;
        @(negedge clock);
        preload_en = 1'b0;
        base = u_datapath_model.log_size();
        id = r.id;
        move = r.move;
        draw_start = (r.op != op_update);
        update_start = (r.op != op_draw);
        @(negedge clock);
        draw_start = 1'b0;
        update_start = 1'b0;
        if (r.op != op_update) check_finished("draw_finished", draw_finished, 1'b0);
        if (r.op != op_draw) check_finished("update_finished", update_finished, 1'b0);
        if (r.op == op_update) begin
            while (!update_finished) @(negedge clock);
            check_finished("draw_finished", draw_finished, 1'b1);
        end else begin
            // Draw is the last to finish, also after a collision
            while (!draw_finished) @(negedge clock);
            check_finished("update_finished", update_finished, 1'b1);
        end
        ux = expected_x(r.x, r.move);
        uy = expected_y(r.y, r.move);
        case (r.op)
            op_draw: begin
                expect_log_length(base, 2 + ant_width * ant_height);
                expect_draw_stream(base, r.id, r.x, r.y);
            end
            op_update: begin
                expect_log_length(base, 6);
                expect_update_stream(base, r, ux, uy);
            end
            default: begin
                // Update wins the collision, draw then sees the moved ant
                expect_log_length(base, 8 + ant_width * ant_height);
                expect_update_stream(base, r, ux, uy);
                expect_draw_stream(base + 6, r.id, ux, uy);
            end
        endcase
    endtask

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clock);
        stop_with_failure("Watchdog expired before all stimulus rows completed");
    endtask

    // Start level lasts two cycles and only follows a finished datapath
    always @(negedge clock) begin
        if (!resetn) begin
            start_cycles = 0;
            finished_seen = 1'b1;
        end else if (start_dp) begin
            if (start_cycles == 0 && !finished_seen) begin
                stop_with_failure("start_dp rose before finished_dp ended the previous command");
            end
            finished_seen = 1'b0;
            start_cycles++;
        end else begin
            if (start_cycles != 0 && start_cycles != 2) begin
                stop_with_failure($sformatf("start_dp was high for %0d cycles instead of 2",
                                            start_cycles));
            end
            start_cycles = 0;
            if (finished_dp) finished_seen = 1'b1;
        end
    end

    initial begin
        void'($urandom(8768));
        resetn = 1'b0;
        draw_start = 1'b0;
        update_start = 1'b0;
        id = '0;
        move = '0;
        preload_en = 1'b0;
        preload_id = '0;
        preload_x = '0;
        preload_y = '0;
        preload_fitness = '0;
        load_table();
        fork
            run_watchdog(rows.size() * 200);
        join_none
        repeat (2) @(negedge clock);
        resetn = 1'b1;
        @(negedge clock);
        check_finished("draw_finished", draw_finished, 1'b1);
        check_finished("update_finished", update_finished, 1'b1);
        check_finished("start_dp", start_dp, 1'b0);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: test/tb_datapath_model.sv
`timescale 1ns/10ps

module tb_datapath_model (
    input logic clock,
    input logic resetn,
    input logic start_dp,
    input ant_pkg::instr_u instruction_dp,
    output logic finished_dp,
    output ant_pkg::result_t result_dp,
    input logic preload_en,
    input logic [ant_pkg::id_width-1:0] preload_id,
    input ant_pkg::result_t preload_x,
    input ant_pkg::result_t preload_y,
    input ant_pkg::result_t preload_fitness
);
    import ant_pkg::*;

    localparam int mem_depth = 1 << mem_addr_width;

    result_t mem [mem_depth];
    instr_u log_q[$];
    logic [mem_addr_width-1:0] fill_addr;
    logic start_q;
    logic busy;
    int unsigned delay;

    function automatic int log_size();
        return log_q.size();
    endfunction

    function automatic instr_u log_entry(input int idx);
        return log_q[idx];
    endfunction

    function automatic result_t mem_word(input logic [mem_addr_width-1:0] addr);
        return mem[addr];
    endfunction

    // A command is accepted on the rising start level, finished stays high until the next one
    always @(posedge clock) begin
        if (!resetn) begin
            for (int a = 0; a < mem_depth; a++) begin
                fill_addr = mem_addr_width'(a);
                mem[fill_addr] = result_t'({6'h2d, fill_addr});
            end
            start_q <= 1'b0;
            busy <= 1'b0;
            delay <= 0;
            finished_dp <= 1'b0;
            result_dp <= '0;
        end else begin
            start_q <= start_dp;
            if (preload_en) begin
                mem[ant_field_addr(preload_id, field_x)] = preload_x;
                mem[ant_field_addr(preload_id, field_y)] = preload_y;
                mem[ant_field_addr(preload_id, field_fitness)] = preload_fitness;
            end
            if (start_dp && !start_q) begin
                log_q.push_back(instruction_dp);
                finished_dp <= 1'b0;
                busy <= 1'b1;
                delay <= $urandom_range(5, 0);
                // Draw view needs no reply, so only memory ops touch the result
                case (instruction_dp.mem.opcode)
                    opcode_memread: result_dp <= mem[instruction_dp.mem.addr];
                    opcode_memwrite: mem[instruction_dp.mem.addr] = instruction_dp.mem.data;
                    default: result_dp <= '0;
                endcase
            end else if (busy) begin
                if (delay == 0) begin
                    finished_dp <= 1'b1;
                    busy <= 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule
